//--- taskSched.f
schedPkg.sv
corePkg.sv
taskMemory.sv
frameDecoder.sv
dispatchControl.sv
insnStreamer.sv
coreCluster.sv
taskSchedTop.sv
taskSchedTb.sv

//--- schedTrace.txt
# W addr frame writes one frame, G runs from address 0 until done
# E acc0 acc1 acc2 acc3 starts overlap, starts nibble n counts core n start pulses, overlap 1 requires one
# Program 1 one task with R0 init on cores 0 and 1
W 0 00000001A0919801
W 1 0000110020F01005
W 2 0000000000000000
G
E 01E7 01C9 0000 0000 0011 0
# Program 2 three instruction frames on core 2
W 0 0000000800022003
W 1 1004100310021001
W 2 10010000101020FF
W 3 0000000012003003
W 4 0000000000000000
G
E 01E7 01C9 0305 0000 0300 0
# Program 3 acquire fence on core 0 holds back the task on core 1
W 0 0000000001008811
W 1 0000000010073014
W 2 0000000200011001
W 3 0000101020011003
W 4 0000000000000000
G
E 0027 0052 0305 0000 0011 0
# Program 4 no fence, core 3 starts while core 0 waits
W 0 0000000000288801
W 1 0000000010113028
W 2 0000500000044001
W 3 10020000200F1100
W 4 0000000000000000
G
E 0016 0052 0305 0107 1001 1
# Program 5 stop bit jumps from frame 1 over frames 2 to 4
W 0 00000000880112C1
W 1 0000000000001022
W 2 000004C800022002
W 3 0000000000001777
W 4 0000000000001555
W 5 0000000000002001
W 6 0000000020031030
W 7 0000000000000000
G
E 0016 0033 0336 0107 0110 0

//--- taskSchedTb.sv
`timescale 1ns/1ps

module taskSchedTb;

	localparam int cyclesPerProgram = 400;
	localparam int cycleMargin = 200;
	localparam int minStartGap = schedPkg::loadTime + 1;	// Four words plus the start cycle

	logic clk;
	logic reset;
	logic hostWrite;
	logic [schedPkg::ptrWidth-1:0] hostAddr;
	logic [schedPkg::frameWidth-1:0] hostData;
	logic hostGo;
	logic busy;
	logic done;
	logic [corePkg::numCores-1:0] coreStart;
	logic [corePkg::numCores-1:0] coreReady;
	logic [corePkg::numCores*corePkg::accWidth-1:0] coreAcc;

	int traceFd;
	int cycle = 0;
	int cycleLimit = cycleMargin;
	int errors = 0;
	int testErrStart = 0;
	int passCount = 0;
	int failCount = 0;
	int programCount = 0;
	int testedPrograms = 0;
	int doneCount = 0;
	int overlapCount = 0;
	int startCount [corePkg::numCores];
	int lastStart [corePkg::numCores];
	logic inProgram = 1'b0;
	logic prevDone = 1'b0;
	logic prevBusy = 1'b0;

	taskSchedTop u_dut
	(
		.clk(clk),
		.reset(reset),
		.hostWrite(hostWrite),
		.hostAddr(hostAddr),
		.hostData(hostData),
		.hostGo(hostGo),
		.busy(busy),
		.done(done),
		.coreStart(coreStart),
		.coreReady(coreReady),
		.coreAcc(coreAcc)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycle = cycle + 1;
		if (cycle >= cycleLimit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// Handshake and fence monitors sampled mid-cycle
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (busy && !inProgram)
			begin
				$display("busy is high while no program is running");
				errors++;
			end
			if (done)
			begin
				doneCount++;
				if (busy)
				begin
					$display("busy is still high in the cycle done pulses");
					errors++;
				end
				if (!prevBusy)
				begin
					$display("busy was not high in the cycle before done");
					errors++;
				end
				if (prevDone)
				begin
					$display("done stayed high for more than one cycle");
					errors++;
				end
			end
			prevDone = done;
			prevBusy = busy;
			if (coreStart != '0 && (~coreReady & ~coreStart) != '0)
			begin
				overlapCount++;		// Start while another core is busy
			end
			for (int i = 0; i < corePkg::numCores; i++)
			begin
				if (coreStart[i])
				begin
					if (cycle - lastStart[i] < minStartGap)
					begin
						$display("core %0d started again only %0d cycles after its last start",
							i, cycle - lastStart[i]);
						errors++;
					end
					lastStart[i] = cycle;
					startCount[i]++;
				end
			end
		end
	end

	task automatic checkValue(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			$display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic skipLine(input int fd);
		int c;
		c = $fgetc(fd);
		while (c != 10 && c != -1)
		begin
			c = $fgetc(fd);
		end
	endtask

	// First pass over the trace sets the cycle budget
	task automatic countPrograms();
		int fd;
		int n;
		int kind;
		fd = $fopen("schedTrace.txt", "r");
		if (fd != 0)
		begin
			n = $fscanf(fd, " %c", kind);
			while (n == 1)
			begin
				if (kind == "G")
				begin
					programCount++;
				end
				skipLine(fd);
				n = $fscanf(fd, " %c", kind);
			end
			$fclose(fd);
		end
	endtask

	task automatic writeFrame(input logic [schedPkg::ptrWidth-1:0] addr,
		input logic [schedPkg::frameWidth-1:0] frame);
		@(posedge clk);
		#1;
		hostWrite = 1'b1;
		hostAddr = addr;
		hostData = frame;
		@(posedge clk);
		#1;
		hostWrite = 1'b0;
	endtask

	task automatic runProgram();
		@(posedge clk);
		#1;
		testErrStart = errors;
		doneCount = 0;
		overlapCount = 0;
		for (int i = 0; i < corePkg::numCores; i++)
		begin
			startCount[i] = 0;
		end
		inProgram = 1'b1;
		hostGo = 1'b1;
		@(posedge clk);
		#1;
		hostGo = 1'b0;
		while (!done)
		begin
			@(negedge clk);
		end
		inProgram = 1'b0;
		@(negedge clk);		// Let the done pulse end
	endtask

	task automatic checkResults();
		logic [corePkg::accWidth-1:0] exp0;
		logic [corePkg::accWidth-1:0] exp1;
		logic [corePkg::accWidth-1:0] exp2;
		logic [corePkg::accWidth-1:0] exp3;
		logic [corePkg::numCores*corePkg::accWidth-1:0] expAll;
		logic [15:0] expStarts;
		logic [3:0] overlapMode;
		int n;
		n = $fscanf(traceFd, "%h %h %h %h %h %h", exp0, exp1, exp2, exp3, expStarts,
			overlapMode);
		testedPrograms++;
		if (n != 6)
		begin
			$display("malformed result line for program %0d in the trace", testedPrograms);
			errors++;
		end
		expAll = {exp3, exp2, exp1, exp0};
		for (int i = 0; i < corePkg::numCores; i++)
		begin
			checkValue($sformatf("coreAcc[%0d]", i),
				coreAcc[i*corePkg::accWidth +: corePkg::accWidth],
				expAll[i*corePkg::accWidth +: corePkg::accWidth]);
			checkValue($sformatf("coreStart[%0d] count", i), startCount[i],
				expStarts[i*4 +: 4]);
		end
		checkValue("done count", doneCount, 1);
		checkValue("coreReady", coreReady, 4'hf);
		if (overlapMode == 0)
		begin
			checkValue("overlap count", overlapCount, 0);
		end
		else
		begin
			checkValue("overlap seen", overlapCount > 0, 1);
		end
		if (errors == testErrStart)
		begin
			$display("program %0d: ok", testedPrograms);
			passCount++;
		end
		else
		begin
			$display("program %0d: failed", testedPrograms);
			failCount++;
		end
	endtask

	initial
	begin : mainSeq
		int kind;
		int n;
		logic more;
		logic [schedPkg::ptrWidth-1:0] addr;
		logic [schedPkg::frameWidth-1:0] frame;
		clk = 1'b0;
		reset = 1'b1;
		hostWrite = 1'b0;
		hostAddr = '0;
		hostData = '0;
		hostGo = 1'b0;
		for (int i = 0; i < corePkg::numCores; i++)
		begin
			startCount[i] = 0;
			lastStart[i] = -100;
		end
		countPrograms();
		cycleLimit = cyclesPerProgram * programCount + cycleMargin;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		checkValue("busy", busy, 0);
		checkValue("done", done, 0);
		checkValue("coreStart", coreStart, 0);
		checkValue("coreReady", coreReady, 4'hf);
		if (errors == 0)
		begin
			$display("reset: ok");
			passCount++;
		end
		else
		begin
			$display("reset: failed");
			failCount++;
		end
		traceFd = $fopen("schedTrace.txt", "r");
		if (traceFd == 0)
		begin
			$display("could not open schedTrace.txt");
			$display("=== FAIL ===");
		end
		else
		begin
			more = 1'b1;
			while (more)
			begin
				n = $fscanf(traceFd, " %c", kind);
				if (n != 1)
				begin
					more = 1'b0;
				end
				else if (kind == "#")
				begin
					skipLine(traceFd);
				end
				else if (kind == "W")
				begin
					n = $fscanf(traceFd, "%h %h", addr, frame);
					if (n != 2)
					begin
						$display("malformed frame line in the trace");
						errors++;
						more = 1'b0;
					end
					else
					begin
						writeFrame(addr, frame);
					end
				end
				else if (kind == "G")
				begin
					runProgram();
				end
				else if (kind == "E")
				begin
					checkResults();
				end
				else
				begin
					$display("unknown line kind '%c' in the trace", kind);
					errors++;
					more = 1'b0;
				end
			end
			$fclose(traceFd);
			if (testedPrograms != programCount || programCount == 0)
			begin
				$display("only %0d of %0d programs were checked", testedPrograms, programCount);
				errors++;
			end
			$display("tests passed %0d failed %0d", passCount, failCount);
			if (errors == 0 && failCount == 0)
			begin
				$display("=== PASS ===");
			end
			else
			begin
				$display("=== FAIL ===");
			end
		end
		$finish;
	end

endmodule

//--- taskSchedTop.sv
`timescale 1ns/1ps

module taskSchedTop
(
	input logic clk,
	input logic reset,
	input logic hostWrite,
	input logic [schedPkg::ptrWidth-1:0] hostAddr,
	input logic [schedPkg::frameWidth-1:0] hostData,
	input logic hostGo,
	output logic busy,
	output logic done,
	output logic [corePkg::numCores-1:0] coreStart,
	output logic [corePkg::numCores-1:0] coreReady,
	output logic [corePkg::numCores*corePkg::accWidth-1:0] coreAcc
);

	logic [schedPkg::ptrWidth-1:0] rdPtr;
	logic [schedPkg::frameWidth-1:0] rdFrame;
	schedPkg::decodedT decoded;
	logic issue;
	logic [schedPkg::frameWidth-1:0] issueWords;
	logic [corePkg::numCores-1:0] activeMask;
	logic initStrobe;
	logic [corePkg::numCores-1:0] initMask;
	logic [corePkg::numCores*corePkg::initWidth-1:0] initVal;
	logic streamDone;
	corePkg::coreCmdT cmd;

	taskMemory u_taskMemory
	(
		.clk(clk),
		.reset(reset),
		.hostWrite(hostWrite),
		.hostAddr(hostAddr),
		.hostData(hostData),
		.rdPtr(rdPtr),
		.rdFrame(rdFrame)
	);

	frameDecoder u_frameDecoder
	(
		.clk(clk),
		.reset(reset),
		.rdFrame(rdFrame),
		.decoded(decoded)
	);

	dispatchControl u_dispatchControl
	(
		.clk(clk),
		.reset(reset),
		.hostGo(hostGo),
		.decoded(decoded),
		.coreReady(coreReady),
		.streamDone(streamDone),
		.rdPtr(rdPtr),
		.issue(issue),
		.issueWords(issueWords),
		.activeMask(activeMask),
		.initStrobe(initStrobe),
		.initMask(initMask),
		.initVal(initVal),
		.busy(busy),
		.done(done)
	);

	insnStreamer u_insnStreamer
	(
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.issueWords(issueWords),
		.activeMask(activeMask),
		.initStrobe(initStrobe),
		.initMask(initMask),
		.initVal(initVal),
		.cmd(cmd),
		.coreStart(coreStart),
		.streamDone(streamDone)
	);

	coreCluster u_coreCluster
	(
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.coreStart(coreStart),
		.coreReady(coreReady),
		.coreAcc(coreAcc)
	);

endmodule

//--- coreCluster.sv
`timescale 1ns/1ps

module coreCluster
(
	input logic clk,
	input logic reset,
	input corePkg::coreCmdT cmd,
	input logic [corePkg::numCores-1:0] coreStart,
	output logic [corePkg::numCores-1:0] coreReady,
	output logic [corePkg::numCores*corePkg::accWidth-1:0] coreAcc
);

	genvar i;
	generate
		for (i = 0; i < corePkg::numCores; i++)
		begin : gCore
			corePkg::insnT prog [schedPkg::loadTime];
			corePkg::insnT cur;
			logic [schedPkg::loadIdxWidth-1:0] wrIdx;
			logic [schedPkg::loadCntWidth-1:0] pc;
			logic [corePkg::immWidth-1:0] waitCnt;
			logic [corePkg::accWidth-1:0] acc;
			logic running;
			logic pending;		// Low ready from first word to end of run

			assign cur = prog[pc[schedPkg::loadIdxWidth-1:0]];
			assign coreReady[i] = ~pending;
			assign coreAcc[i*corePkg::accWidth +: corePkg::accWidth] = acc;

			always_ff @(posedge clk)
			begin
				if (cmd.wordValid[i])
				begin
					prog[wrIdx] <= cmd.word;
				end
			end

			always_ff @(posedge clk)
			begin
				if (reset)
				begin
					wrIdx <= '0;
					pc <= '0;
					waitCnt <= '0;
					acc <= '0;
					running <= 1'b0;
					pending <= 1'b0;
				end
				else
				begin
					if (cmd.wordValid[i])
					begin
						wrIdx <= wrIdx + 1'b1;
						pending <= 1'b1;
					end
					if (cmd.initMask[i])
					begin
						acc <= corePkg::accWidth'(cmd.initVal[i]);	// R0 init
					end
					if (cmd.start && coreStart[i])
					begin
						running <= 1'b1;
						pc <= '0;
						wrIdx <= '0;
					end
					else if (running)
					begin
						if (waitCnt != '0)
						begin
							waitCnt <= waitCnt - 1'b1;
						end
						else if (pc == schedPkg::loadTime)
						begin
							running <= 1'b0;
							pending <= 1'b0;
						end
						else
						begin
							case (cur.op)
								corePkg::opAdd: acc <= acc + corePkg::accWidth'(cur.imm);
								corePkg::opXor: acc <= acc ^ corePkg::accWidth'(cur.imm);
								corePkg::opWait: waitCnt <= cur.imm;
								default: ;
							endcase
							pc <= pc + 1'b1;
						end
					end
				end
			end
		end
	endgenerate

endmodule

//--- insnStreamer.sv
`timescale 1ns/1ps

module insnStreamer
(
	input logic clk,
	input logic reset,
	input logic issue,
	input logic [schedPkg::frameWidth-1:0] issueWords,
	input logic [corePkg::numCores-1:0] activeMask,
	input logic initStrobe,
	input logic [corePkg::numCores-1:0] initMask,
	input logic [corePkg::numCores*corePkg::initWidth-1:0] initVal,
	output corePkg::coreCmdT cmd,
	output logic [corePkg::numCores-1:0] coreStart,
	output logic streamDone
);

	logic [schedPkg::frameWidth-1:0] shiftWords;
	logic [corePkg::numCores-1:0] mask;
	logic [schedPkg::loadCntWidth-1:0] loadCnt;
	logic loading;

	always_ff @(posedge clk)
	begin
		cmd.initVal <= initVal;
		if (reset)
		begin
			cmd.wordValid <= '0;
			cmd.start <= 1'b0;
			cmd.initMask <= '0;
			coreStart <= '0;
			streamDone <= 1'b0;
			loadCnt <= '0;
			loading <= 1'b0;
		end
		else
		begin
			cmd.start <= 1'b0;
			coreStart <= '0;
			streamDone <= 1'b0;
			cmd.initMask <= initStrobe ? initMask : '0;
			if (issue)
			begin
				cmd.wordValid <= activeMask;
				cmd.word <= issueWords[corePkg::wordWidth-1:0];
				shiftWords <= issueWords >> corePkg::wordWidth;
				mask <= activeMask;
				loadCnt <= 1;
				loading <= 1'b1;
			end
			else if (loading)
			begin
				if (loadCnt == schedPkg::loadTime)	// All words out
				begin
					cmd.wordValid <= '0;
					cmd.start <= 1'b1;
					coreStart <= mask;
					streamDone <= 1'b1;
					loading <= 1'b0;
				end
				else
				begin
					cmd.word <= shiftWords[corePkg::wordWidth-1:0];
					shiftWords <= shiftWords >> corePkg::wordWidth;
					loadCnt <= loadCnt + 1'b1;
				end
			end
		end
	end

endmodule

//--- dispatchControl.sv
`timescale 1ns/1ps

module dispatchControl
(
	input logic clk,
	input logic reset,
	input logic hostGo,
	input schedPkg::decodedT decoded,
	input logic [corePkg::numCores-1:0] coreReady,
	input logic streamDone,
	output logic [schedPkg::ptrWidth-1:0] rdPtr,
	output logic issue,
	output logic [schedPkg::frameWidth-1:0] issueWords,
	output logic [corePkg::numCores-1:0] activeMask,
	output logic initStrobe,
	output logic [corePkg::numCores-1:0] initMask,
	output logic [corePkg::numCores*corePkg::initWidth-1:0] initVal,
	output logic busy,
	output logic done
);

	typedef enum logic [2:0]
	{
		stIdle,
		stSettle,
		stCtrlWait,
		stIssue,
		stStreamWait,
		stFinish
	} stateT;

	stateT state;
	schedPkg::fenceT fence;
	logic [schedPkg::ptrWidth-1:0] ptr;
	logic [schedPkg::ptrWidth-1:0] remaining;
	logic [schedPkg::ptrWidth-1:0] stopAddr;
	logic settleCnt;
	logic stopPending;
	logic laterFrame;
	logic allReady;
	logic strictFence;
	logic acceptCtrl;
	logic activeReady;

	assign rdPtr = ptr;
	assign allReady = &coreReady;
	assign strictFence = (fence != schedPkg::fenceNo) || (decoded.fence == schedPkg::fenceRel);
	assign acceptCtrl = strictFence ? allReady : ((~coreReady & decoded.coreMask) == '0);
	assign activeReady = (~coreReady & activeMask) == '0;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stIdle;
			fence <= schedPkg::fenceNo;
			ptr <= '0;
			remaining <= '0;
			settleCnt <= 1'b0;
			stopPending <= 1'b0;
			laterFrame <= 1'b0;
			activeMask <= '0;
			issue <= 1'b0;
			initStrobe <= 1'b0;
			initMask <= '0;
			busy <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			issue <= 1'b0;
			initStrobe <= 1'b0;
			done <= 1'b0;
			case (state)
				stIdle:
				begin
					if (hostGo)
					begin
						ptr <= '0;
						fence <= schedPkg::fenceNo;
						remaining <= '0;
						settleCnt <= 1'b0;
						busy <= 1'b1;
						state <= stSettle;
					end
				end
				stSettle:		// Memory read plus decode
				begin
					if (settleCnt)
					begin
						settleCnt <= 1'b0;
						state <= (remaining == '0) ? stCtrlWait : stIssue;
					end
					else
					begin
						settleCnt <= 1'b1;
					end
				end
				stCtrlWait:
				begin
					if (decoded.frameCount == '0)
					begin
						state <= stFinish;	// End of program
					end
					else if (acceptCtrl)
					begin
						fence <= decoded.fence;
						activeMask <= decoded.coreMask;
						remaining <= decoded.frameCount;
						stopPending <= decoded.stop;
						stopAddr <= decoded.stopAddr;
						initStrobe <= 1'b1;
						initMask <= decoded.r0Mask;
						initVal <= decoded.r0Val;
						laterFrame <= 1'b0;
						ptr <= ptr + 1'b1;
						state <= stSettle;
					end
				end
				stIssue:
				begin
					if (!laterFrame || activeReady)
					begin
						issue <= 1'b1;
						issueWords <= decoded.words;
						state <= stStreamWait;
					end
				end
				stStreamWait:
				begin
					if (streamDone)
					begin
						laterFrame <= 1'b1;
						remaining <= remaining - 1'b1;
						state <= stSettle;
						if (remaining == 1 && stopPending)
						begin
							ptr <= stopAddr;
							fence <= schedPkg::fenceRel;	// Drain all cores
							stopPending <= 1'b0;
						end
						else
						begin
							ptr <= ptr + 1'b1;
						end
					end
				end
				stFinish:
				begin
					if (allReady)
					begin
						done <= 1'b1;
						busy <= 1'b0;
						state <= stIdle;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

//--- frameDecoder.sv
`timescale 1ns/1ps

module frameDecoder
(
	input logic clk,
	input logic reset,
	input logic [schedPkg::frameWidth-1:0] rdFrame,
	output schedPkg::decodedT decoded
);

	schedPkg::ctrlFrameT ctrl;
	schedPkg::fenceT fenceCode;

	assign ctrl = rdFrame;

	// Unused code 3 falls back to no fence
	always_comb
	begin
		case (ctrl.fence)
			2'd1: fenceCode = schedPkg::fenceAcq;
			2'd2: fenceCode = schedPkg::fenceRel;
			default: fenceCode = schedPkg::fenceNo;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			decoded <= '0;
		end
		else
		begin
			decoded.frameCount <= ctrl.frameCount;
			decoded.fence <= fenceCode;
			decoded.stop <= ctrl.stop;
			decoded.stopAddr <= ctrl.stopAddr;
			decoded.coreMask <= ctrl.coreMask;
			decoded.r0Mask <= ctrl.r0Mask;
			decoded.r0Val <= ctrl.r0Val;
			decoded.words <= rdFrame;	// Same bits viewed as instruction words
		end
	end

endmodule

//--- taskMemory.sv
`timescale 1ns/1ps

module taskMemory
(
	input logic clk,
	input logic reset,
	input logic hostWrite,
	input logic [schedPkg::ptrWidth-1:0] hostAddr,
	input logic [schedPkg::frameWidth-1:0] hostData,
	input logic [schedPkg::ptrWidth-1:0] rdPtr,
	output logic [schedPkg::frameWidth-1:0] rdFrame
);

	logic [schedPkg::frameWidth-1:0] mem [schedPkg::taskDepth];

	always_ff @(posedge clk)
	begin
		if (hostWrite)
		begin
			mem[hostAddr] <= hostData;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rdFrame <= '0;
		end
		else
		begin
			rdFrame <= mem[rdPtr];		// One cycle read latency
		end
	end

endmodule

//--- corePkg.sv
package corePkg;

	localparam int numCores = 4;
	localparam int wordWidth = 16;
	localparam int accWidth = 16;
	localparam int immWidth = wordWidth - 4;
	localparam int initWidth = 8;			// R0 init value width

	typedef enum logic [3:0]
	{
		opNop = 4'd0,
		opAdd = 4'd1,
		opXor = 4'd2,
		opWait = 4'd3
	} opT;

	typedef struct packed
	{
		opT op;
		logic [immWidth-1:0] imm;
	} insnT;

	typedef struct packed
	{
		logic [numCores-1:0] wordValid;		// Per-core word strobe
		logic [wordWidth-1:0] word;
		logic start;
		logic [numCores-1:0] initMask;
		logic [numCores-1:0][initWidth-1:0] initVal;
	} coreCmdT;

endpackage

//--- schedPkg.sv
package schedPkg;

	localparam int taskDepth = 16;
	localparam int ptrWidth = 4;
	localparam int frameWidth = 64;
	localparam int loadTime = 4;			// Instruction words per frame
	localparam int loadIdxWidth = $clog2(loadTime);
	localparam int loadCntWidth = $clog2(loadTime + 1);

	typedef enum logic [1:0]
	{
		fenceNo = 2'd0,
		fenceAcq = 2'd1,
		fenceRel = 2'd2
	} fenceT;

	// Raw control frame with frameCount in the low bits
	typedef struct packed
	{
		logic [12:0] spare;
		logic [3:0][7:0] r0Val;
		logic [3:0] r0Mask;
		logic [3:0] coreMask;
		logic [ptrWidth-1:0] stopAddr;
		logic stop;
		logic [1:0] fence;
		logic [ptrWidth-1:0] frameCount;
	} ctrlFrameT;

	typedef struct packed
	{
		logic [ptrWidth-1:0] frameCount;
		fenceT fence;
		logic stop;
		logic [ptrWidth-1:0] stopAddr;
		logic [3:0] coreMask;
		logic [3:0] r0Mask;
		logic [3:0][7:0] r0Val;
		logic [loadTime-1:0][frameWidth/loadTime-1:0] words;	// Word 0 streams first
	} decodedT;

endpackage
